// ==== testbench/lsu_vectors.txt ====
// op base offset data flag expect
// op 0 load, 1 store, 2 idle for base cycles; flag 1 commit, 0 discard
1 00000020 00000020 a5a50001 1 00000000
2 0000000c 00000000 00000000 0 00000000
0 00000040 00000000 00000000 0 a5a50001
0 00000070 00000010 00000000 0 00000000
1 00000044 00000000 00c0ffee 1 00000000
0 00000040 00000004 00000000 0 00c0ffee
1 00000048 00000000 11110000 1 00000000
1 00000040 00000008 22220000 1 00000000
0 00000048 00000000 00000000 0 22220000
0 00000000 00000040 00000000 0 a5a50001
1 0000004c 00000000 dead0001 0 00000000
0 0000004c 00000000 00000000 0 00000000
2 00000008 00000000 00000000 0 00000000
0 0000004c 00000000 00000000 0 00000000
1 00000040 00000000 bad00002 0 00000000
0 00000040 00000000 00000000 0 a5a50001
2 00000008 00000000 00000000 0 00000000
0 00000040 00000000 00000000 0 a5a50001
1 00000050 00000000 50500001 1 00000000
1 00000050 00000000 50500002 0 00000000
0 00000050 00000000 00000000 0 50500001
2 0000000c 00000000 00000000 0 00000000
1 00000080 00000000 80000000 1 00000000
1 00000080 00000004 80000001 1 00000000
1 00000080 00000008 80000002 1 00000000
1 00000080 0000000c 80000003 1 00000000
1 00000080 00000010 80000004 1 00000000
1 00000080 00000014 80000005 1 00000000
1 00000080 00000018 80000006 1 00000000
1 00000080 0000001c 80000007 1 00000000
0 00000080 00000004 00000000 0 80000001
2 0000001e 00000000 00000000 0 00000000
0 00000080 00000000 00000000 0 80000000
0 00000080 00000004 00000000 0 80000001
0 00000080 00000008 00000000 0 80000002
0 00000080 0000000c 00000000 0 80000003
0 00000080 00000010 00000000 0 80000004
0 00000080 00000014 00000000 0 80000005
0 00000080 00000018 00000000 0 80000006
0 00000080 0000001c 00000000 0 80000007

// ==== tb.f ====
hdl/tartaruga_pkg.sv
hdl/address_stage.sv
hdl/store_buffer.sv
hdl/data_memory.sv
hdl/load_return.sv
hdl/lsu_top.sv
testbench/tb_lsu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_lsu -o tb_lsu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi

// ==== testbench/tb_lsu.sv ====
module tb_lsu;

    localparam int FIELDS      = 6;
    localparam int MAX_VECTORS = 64;

    logic                                        clk_i;
    logic                                        rstn_i;
    logic                                        req_valid_i;
    tartaruga_pkg::lsu_req_t                     req_i;
    logic                                        req_ready_o;
    logic                                        sb_alloc_valid_o;
    tartaruga_pkg::store_buffer_idx_t            sb_alloc_o;
    logic                                        commit_i;
    tartaruga_pkg::store_buffer_idx_t            commit_idx_i;
    logic [tartaruga_pkg::STORE_BUFFER_SIZE-1:0] discard_i;
    logic                                        load_valid_o;
    tartaruga_pkg::bus32_t                       load_data_o;

    // Flat vector storage, FIELDS words per vector
    tartaruga_pkg::bus32_t vec_mem [FIELDS*MAX_VECTORS];

    tartaruga_pkg::bus32_t            exp_data_q [$];
    int                               issue_q [$];
    bit                               flag_q [$];
    logic                             action_valid;
    logic                             action_commit;
    tartaruga_pkg::store_buffer_idx_t action_idx;

    int vec_cnt      = 0;
    int cycle_cnt    = 0;
    int cycle_limit  = 100;
    int check_cnt    = 0;
    int error_cnt    = 0;
    int load_cnt     = 0;
    int alloc_cnt    = 0;
    int stall_cycles = 0;

    lsu_top i_dut (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .req_valid_i      (req_valid_i),
        .req_i            (req_i),
        .req_ready_o      (req_ready_o),
        .sb_alloc_valid_o (sb_alloc_valid_o),
        .sb_alloc_o       (sb_alloc_o),
        .commit_i         (commit_i),
        .commit_idx_i     (commit_idx_i),
        .discard_i        (discard_i),
        .load_valid_o     (load_valid_o),
        .load_data_o      (load_data_o)
    );

    always begin
        #10 clk_i = ~clk_i;
    end

    // Tag for vector slots the file leaves unwritten, never a valid opcode
    function automatic tartaruga_pkg::bus32_t unread_tag(input int i);
        return 32'hffff_0000 | tartaruga_pkg::bus32_t'(i);
    endfunction

    task automatic check_value(input string what, input tartaruga_pkg::bus32_t got,
                               input tartaruga_pkg::bus32_t expected);
        check_cnt++;
        if (got !== expected) begin
            error_cnt++;
            $display("ERROR at time %0t: %s mismatch, got %h, expected %h",
                     $time, what, got, expected);
        end
    endtask

    // Called at the falling edge before the edge that takes the request
    task automatic record_issue(input int n);
        if (req_i.is_store) begin
            flag_q.push_back(vec_mem[FIELDS*n + 4][0]);
        end else begin
            exp_data_q.push_back(vec_mem[FIELDS*n + 5]);
            issue_q.push_back(cycle_cnt + 1);
        end
    endtask

    task automatic issue_vector(input int n);
        tartaruga_pkg::bus32_t op;
        tartaruga_pkg::bus32_t cycles;
        logic                  accepted;
        op = vec_mem[FIELDS*n];
        if (op == 32'd2) begin
            cycles = vec_mem[FIELDS*n + 1];
            repeat (cycles) begin
                @(posedge clk_i);
                #2;
            end
        end else if (op == 32'd0 || op == 32'd1) begin
            req_valid_i    = 1'b1;
            req_i.is_store = op[0];
            req_i.base     = vec_mem[FIELDS*n + 1];
            req_i.offset   = vec_mem[FIELDS*n + 2];
            req_i.data     = vec_mem[FIELDS*n + 3];
            accepted       = 1'b0;
            while (!accepted) begin
                @(negedge clk_i);
                accepted = req_ready_o;
                if (accepted) begin
                    record_issue(n);
                end
                @(posedge clk_i);
                #2;
            end
            req_valid_i = 1'b0;
        end else begin
            error_cnt++;
            $display("Vector %0d has unknown operation code %0h and was skipped", n, op);
        end
    endtask

    task automatic watch_loads();
        tartaruga_pkg::bus32_t expected;
        int                    issue_edge;
        if (!load_valid_o) begin
            return;
        end
        if (exp_data_q.size() == 0) begin
            error_cnt++;
            $display("A load result appeared at time %0t with no load outstanding", $time);
        end else begin
            expected   = exp_data_q.pop_front();
            issue_edge = issue_q.pop_front();
            load_cnt++;
            check_value("load data", load_data_o, expected);
            check_value("load latency in cycles",
                        tartaruga_pkg::bus32_t'(cycle_cnt - issue_edge), 32'd2);
        end
    endtask

    // Commit unit answers each allocation one cycle later
    task automatic watch_allocs();
        if (!sb_alloc_valid_o) begin
            return;
        end
        if (flag_q.size() == 0) begin
            error_cnt++;
            $display("Store buffer allocated an entry at time %0t with no store outstanding",
                     $time);
        end else begin
            check_value("store buffer index", tartaruga_pkg::bus32_t'(sb_alloc_o),
                        tartaruga_pkg::bus32_t'(alloc_cnt % tartaruga_pkg::STORE_BUFFER_SIZE));
            alloc_cnt++;
            action_commit = flag_q.pop_front();
            action_idx    = sb_alloc_o;
            action_valid  = 1'b1;
        end
    endtask

    always @(negedge clk_i) begin
        if (rstn_i) begin
            if (req_valid_i && !req_ready_o) begin
                stall_cycles++;
            end
            watch_loads();
            watch_allocs();
        end
    end

    always @(posedge clk_i) begin
        #2;
        commit_i  = 1'b0;
        discard_i = '0;
        if (action_valid) begin
            if (action_commit) begin
                commit_i     = 1'b1;
                commit_idx_i = action_idx;
            end else begin
                discard_i[action_idx] = 1'b1;
            end
            action_valid = 1'b0;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("The run timed out after %0d cycles, %0d loads never returned a result",
                     cycle_cnt, exp_data_q.size());
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        clk_i        = 1'b0;
        rstn_i       = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        commit_i     = 1'b0;
        commit_idx_i = '0;
        discard_i    = '0;
        action_valid  = 1'b0;
        action_commit = 1'b0;
        action_idx    = '0;

        for (int i = 0; i < FIELDS*MAX_VECTORS; i++) begin
            vec_mem[i] = unread_tag(i);
        end
        $readmemh("testbench/lsu_vectors.txt", vec_mem);
        while (vec_cnt < MAX_VECTORS
               && vec_mem[FIELDS*vec_cnt] != unread_tag(FIELDS*vec_cnt)) begin
            vec_cnt++;
        end
        if (vec_cnt == 0) begin
            error_cnt++;
            $display("No vectors could be read from testbench/lsu_vectors.txt");
        end
        cycle_limit = 40 * vec_cnt + 100;

        repeat (10) @(posedge clk_i);
        #2;
        rstn_i = 1'b1;

        // Idle outputs straight after reset
        @(negedge clk_i);
        check_value("req_ready_o after reset", tartaruga_pkg::bus32_t'(req_ready_o), 32'd1);
        check_value("load_valid_o after reset", tartaruga_pkg::bus32_t'(load_valid_o), 32'd0);
        check_value("sb_alloc_valid_o after reset",
                    tartaruga_pkg::bus32_t'(sb_alloc_valid_o), 32'd0);

        @(posedge clk_i);
        #2;
        for (int n = 0; n < vec_cnt; n++) begin
            issue_vector(n);
        end

        while (exp_data_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (4) @(posedge clk_i);

        if (stall_cycles == 0) begin
            error_cnt++;
            $display("req_ready_o never went low, the store burst did not fill the buffer");
        end
        if (flag_q.size() != 0) begin
            error_cnt++;
            $display("%0d stores never reached the store buffer", flag_q.size());
        end

        $display("Checks: %0d, errors: %0d, loads returned: %0d, stores allocated: %0d",
                 check_cnt, error_cnt, load_cnt, alloc_cnt);
        if (error_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/lsu_top.sv ====
module lsu_top (
    input  logic                                        clk_i,
    input  logic                                        rstn_i,

    input  logic                                        req_valid_i,
    input  tartaruga_pkg::lsu_req_t                     req_i,
    output logic                                        req_ready_o,

    output logic                                        sb_alloc_valid_o,
    output tartaruga_pkg::store_buffer_idx_t            sb_alloc_o,
    input  logic                                        commit_i,
    input  tartaruga_pkg::store_buffer_idx_t            commit_idx_i,
    input  logic [tartaruga_pkg::STORE_BUFFER_SIZE-1:0] discard_i,

    output logic                                        load_valid_o,
    output tartaruga_pkg::bus32_t                       load_data_o
);

    tartaruga_pkg::mem_op_t op;
    tartaruga_pkg::mem_wr_t mem_wr;
    tartaruga_pkg::bus32_t  fwd_data;
    tartaruga_pkg::bus32_t  mem_rd_data;
    logic                   store_valid;
    logic                   load_valid;
    logic                   sb_ready;
    logic                   bypass;
    logic                   mem_wr_valid;
    logic                   mem_wr_ready;

    assign store_valid      = op.valid && op.is_store;
    assign load_valid       = op.valid && !op.is_store;
    assign sb_alloc_valid_o = store_valid && sb_ready;

    address_stage i_address_stage (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .req_ready_o   (req_ready_o),
        .op_o          (op),
        .store_ready_i (sb_ready)
    );

    store_buffer i_store_buffer (
        .clk_i                     (clk_i),
        .rstn_i                    (rstn_i),
        .data_i                    (op.data),
        .addr_i                    (op.addr),
        .req_valid_i               (store_valid),
        .req_ready_o               (sb_ready),
        .load_addr_i               (op.addr),
        .bypass_o                  (bypass),
        .data_rd_o                 (fwd_data),
        .wr_valid_o                (mem_wr_valid),
        .wr_ready_i                (mem_wr_ready),
        .wr_o                      (mem_wr),
        .store_buffer_idx_o        (sb_alloc_o),
        .store_buffer_commit_i     (commit_i),
        .store_buffer_idx_commit_i (commit_idx_i),
        .store_buffer_discard_i    (discard_i)
    );

    data_memory i_data_memory (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .wr_valid_i (mem_wr_valid),
        .wr_ready_o (mem_wr_ready),
        .wr_i       (mem_wr),
        .rd_addr_i  (op.addr),
        .rd_data_o  (mem_rd_data)
    );

    load_return i_load_return (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .load_valid_i  (load_valid),
        .bypass_i      (bypass),
        .bypass_data_i (fwd_data),
        .mem_data_i    (mem_rd_data),
        .load_valid_o  (load_valid_o),
        .load_data_o   (load_data_o)
    );

endmodule

// ==== hdl/load_return.sv ====
module load_return (
    input  logic                  clk_i,
    input  logic                  rstn_i,

    input  logic                  load_valid_i,
    input  logic                  bypass_i,
    input  tartaruga_pkg::bus32_t bypass_data_i,
    input  tartaruga_pkg::bus32_t mem_data_i,

    output logic                  load_valid_o,
    output tartaruga_pkg::bus32_t load_data_o
);

    logic                  valid_q;
    logic                  bypass_q;
    tartaruga_pkg::bus32_t bypass_data_q;
    tartaruga_pkg::bus32_t load_data_d;

    // Delay one cycle to meet the synchronous memory read
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q      <= 1'b0;
            bypass_q     <= 1'b0;
            load_valid_o <= 1'b0;
        end else begin
            valid_q      <= load_valid_i;
            bypass_q     <= bypass_i;
            load_valid_o <= valid_q;
        end
    end

    // Forwarded store data beats memory
    assign load_data_d = bypass_q ? bypass_data_q : mem_data_i;

    always_ff @(posedge clk_i) begin
        bypass_data_q <= bypass_data_i;
        if (valid_q) begin
            load_data_o <= load_data_d;
        end
    end

endmodule

// ==== hdl/data_memory.sv ====
module data_memory (
    input  logic                   clk_i,
    input  logic                   rstn_i,

    input  logic                   wr_valid_i,
    output logic                   wr_ready_o,
    input  tartaruga_pkg::mem_wr_t wr_i,

    input  tartaruga_pkg::bus32_t  rd_addr_i,
    output tartaruga_pkg::bus32_t  rd_data_o
);

    tartaruga_pkg::bus32_t   mem_q [tartaruga_pkg::MEM_WORDS];
    tartaruga_pkg::mem_idx_t wr_idx;
    tartaruga_pkg::mem_idx_t rd_idx;
    logic                    wr_busy_q;
    logic                    wr_fire;

    assign wr_idx = wr_i.addr[tartaruga_pkg::MEM_IDX_MSB:tartaruga_pkg::MEM_IDX_LSB];
    assign rd_idx = rd_addr_i[tartaruga_pkg::MEM_IDX_MSB:tartaruga_pkg::MEM_IDX_LSB];

    // One dead cycle after every write
    assign wr_ready_o = !wr_busy_q;
    assign wr_fire    = wr_valid_i && wr_ready_o;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_busy_q <= 1'b0;
            for (int i = 0; i < tartaruga_pkg::MEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            wr_busy_q <= wr_fire;
            if (wr_fire) begin
                mem_q[wr_idx] <= wr_i.data;
            end
        end
    end

    // Read returns the old word on a same-edge write
    always_ff @(posedge clk_i) begin
        rd_data_o <= mem_q[rd_idx];
    end

    // A write held off by the recovery cycle stays offered unchanged
    a_wr_held : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (wr_valid_i && !wr_ready_o) |=> (wr_valid_i && $stable(wr_i))
    );

endmodule

// ==== hdl/store_buffer.sv ====
module store_buffer (
    input  logic                                          clk_i,
    input  logic                                          rstn_i,

    input  tartaruga_pkg::bus32_t                         data_i,
    input  tartaruga_pkg::bus32_t                         addr_i,
    input  logic                                          req_valid_i,
    output logic                                          req_ready_o,

    input  tartaruga_pkg::bus32_t                         load_addr_i,
    output logic                                          bypass_o,
    output tartaruga_pkg::bus32_t                         data_rd_o,

    output logic                                          wr_valid_o,
    input  logic                                          wr_ready_i,
    output tartaruga_pkg::mem_wr_t                        wr_o,

    output tartaruga_pkg::store_buffer_idx_t              store_buffer_idx_o,
    input  logic                                          store_buffer_commit_i,
    input  tartaruga_pkg::store_buffer_idx_t              store_buffer_idx_commit_i,
    input  logic [tartaruga_pkg::STORE_BUFFER_SIZE-1:0]   store_buffer_discard_i
);

    typedef struct packed {
        tartaruga_pkg::bus32_t data;
        tartaruga_pkg::bus32_t addr;
        logic                  valid;
        logic                  committed;
        logic                  discarded;
    } sb_entry_t;

    sb_entry_t entry_q [tartaruga_pkg::STORE_BUFFER_SIZE];
    sb_entry_t entry_d [tartaruga_pkg::STORE_BUFFER_SIZE];

    tartaruga_pkg::store_buffer_idx_t head_q, head_d;
    tartaruga_pkg::store_buffer_idx_t tail_q, tail_d;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q <= '0;
            tail_q <= '0;
            for (int i = 0; i < tartaruga_pkg::STORE_BUFFER_SIZE; i++) begin
                entry_q[i] <= '0;
            end
        end else begin
            head_q <= head_d;
            tail_q <= tail_d;
            for (int i = 0; i < tartaruga_pkg::STORE_BUFFER_SIZE; i++) begin
                entry_q[i] <= entry_d[i];
            end
        end
    end

    // Full when the tail has caught up with a live head
    assign req_ready_o        = !((tail_q == head_q) && entry_q[head_q].valid);
    assign store_buffer_idx_o = tail_q;

    // Head drains only once committed
    assign wr_valid_o = entry_q[head_q].valid && entry_q[head_q].committed;
    assign wr_o       = '{addr: entry_q[head_q].addr, data: entry_q[head_q].data};

    always_comb begin
        for (int i = 0; i < tartaruga_pkg::STORE_BUFFER_SIZE; i++) begin
            entry_d[i] = entry_q[i];
        end
        head_d = head_q;
        tail_d = tail_q;

        if (req_valid_i && req_ready_o) begin
            entry_d[tail_q] = '{
                data      : data_i,
                addr      : addr_i,
                valid     : 1'b1,
                committed : 1'b0,
                discarded : 1'b0
            };
            tail_d = tail_q + 1'b1;
        end

        if (wr_valid_o && wr_ready_i) begin
            entry_d[head_q].valid = 1'b0;
            head_d = head_q + 1'b1;
        end else if (entry_q[head_q].valid && entry_q[head_q].discarded) begin
            // Dropped without a memory write
            entry_d[head_q].valid = 1'b0;
            head_d = head_q + 1'b1;
        end

        if (store_buffer_commit_i) begin
            entry_d[store_buffer_idx_commit_i].committed = 1'b1;
        end
        for (int i = 0; i < tartaruga_pkg::STORE_BUFFER_SIZE; i++) begin
            if (store_buffer_discard_i[i]) begin
                entry_d[i].discarded = 1'b1;
            end
        end
    end

    // Youngest live match wins, discarded stores stay invisible
    always_comb begin
        tartaruga_pkg::store_buffer_idx_t idx;
        bypass_o  = 1'b0;
        data_rd_o = '0;
        for (int k = 1; k <= tartaruga_pkg::STORE_BUFFER_SIZE; k++) begin
            idx = tail_q - tartaruga_pkg::store_buffer_idx_t'(k);
            if (!bypass_o && entry_q[idx].valid && !entry_q[idx].discarded
                && !store_buffer_discard_i[idx] && (entry_q[idx].addr == load_addr_i)) begin
                bypass_o  = 1'b1;
                data_rd_o = entry_q[idx].data;
            end
        end
    end

    a_commit_live : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        store_buffer_commit_i |-> entry_q[store_buffer_idx_commit_i].valid
    );

    // Tail slot must be free whenever a store is taken
    a_no_overwrite : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (req_valid_i && req_ready_o) |-> !entry_q[tail_q].valid
    );

    a_wr_stable : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (wr_valid_o && !wr_ready_i) |=> (wr_valid_o && $stable(wr_o))
    );

endmodule

// ==== hdl/address_stage.sv ====
module address_stage (
    input  logic                    clk_i,
    input  logic                    rstn_i,

    input  logic                    req_valid_i,
    input  tartaruga_pkg::lsu_req_t req_i,
    output logic                    req_ready_o,

    output tartaruga_pkg::mem_op_t  op_o,
    input  logic                    store_ready_i
);

    logic                  valid_q;
    logic                  is_store_q;
    tartaruga_pkg::bus32_t addr_q;
    tartaruga_pkg::bus32_t data_q;
    logic                  advance;

    // Loads always move on, a held store waits for the buffer
    assign advance     = !valid_q || !is_store_q || store_ready_i;
    assign req_ready_o = advance;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else if (advance) begin
            valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance && req_valid_i) begin
            is_store_q <= req_i.is_store;
            addr_q     <= req_i.base + req_i.offset;
            data_q     <= req_i.data;
        end
    end

    assign op_o = '{
        valid    : valid_q,
        is_store : is_store_q,
        addr     : addr_q,
        data     : data_q
    };

    // Only whole words reach the buffer and memory
    a_addr_aligned : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        valid_q |-> (addr_q[1:0] == 2'b00)
    );

endmodule

// ==== hdl/tartaruga_pkg.sv ====
package tartaruga_pkg;

    typedef logic [31:0] bus32_t;

    // Store buffer sizing
    localparam int STORE_BUFFER_SIZE = 4;
    typedef logic [$clog2(STORE_BUFFER_SIZE)-1:0] store_buffer_idx_t;

    // Data memory is word addressed through addr[7:2]
    localparam int MEM_WORDS   = 64;
    localparam int MEM_IDX_LSB = 2;
    localparam int MEM_IDX_MSB = MEM_IDX_LSB + $clog2(MEM_WORDS) - 1;
    typedef logic [$clog2(MEM_WORDS)-1:0] mem_idx_t;

    // Request as it arrives at the top
    typedef struct packed {
        logic   is_store;
        bus32_t base;
        bus32_t offset;
        bus32_t data;
    } lsu_req_t;

    // Output of the address stage
    typedef struct packed {
        logic   valid;
        logic   is_store;
        bus32_t addr;
        bus32_t data;
    } mem_op_t;

    // Drain write from store buffer to memory
    typedef struct packed {
        bus32_t addr;
        bus32_t data;
    } mem_wr_t;

endpackage
